/* source/ion_samples.hex */
// one line per table entry, entry 0 is the marker and 60 to 63 are unused
// flag, level, gain, timestamp and ion count as 1, 2, 2, 4 and 4 hex digits
0000000000000
03C64002001F4
0416400400213
047640060022A
04E6400800251
1556400A00288
05B6400C002B6
0606500E002D9
0666401000301
06A6401200322
06F6401400347
0736401600360
1786401800395
07C6401A003B0
0806401C003C8
0836401E003E1
08564020003F7
0886402200410
08A6402400424
08B6502600433
08D6402800441
08E6402A0044C
08E6402C00452
08F6402E00458
08F640300045B
08E6403200457
08D6403400450
18B6403600446
0896403800439
0866403A00427
0836403C00412
07F6403E003FA
07B64040003DE
07765042003C1
07264044003A2
06D6404600380
068640480035E
0636404A0033B
05E6404C00319
0596404E002F7
15464050002D5
05064052002B4
04C6405400296
0486405600279
045640580025F
0426405A00248
0406505C00234
03E6405E00223
03D6406000216
03C640620020C
03C6406400206
13D6406600203
03E6406800204
0406406A00209
0426406C00212
0456406E0021E
048640700022E
04C6407200241
0506507400257
0546407600270
0000000000000
0000000000000
0000000000000
0000000000000

/* list.f */
+incdir+verification
source/ion_packet_pkg.sv
source/ion_control_pkg.sv
source/sample_timer.sv
source/sample_sequencer.sv
source/sample_table.sv
source/packet_assembler.sv
source/ion_sensor.sv
verification/ion_sensor_tb.sv

/* verification/packet_model.svh */
// ------------------------------
// packet model
// predicts each ion packet from the
// sample file and the fixed field values
// ------------------------------
`ifndef PACKET_MODEL_SVH
`define PACKET_MODEL_SVH

sample_fields_t expected_samples [0:table_depth-1];

// entry the next ready pulse should carry
int expected_entry;

task automatic load_samples();
	$readmemh(sample_file, expected_samples);
endtask

function automatic logic [packet_width-1:0] predict_packet(int entry);
	sample_fields_t s;
	logic [packet_width-1:0] result;
	s = expected_samples[entry];
	if (entry == 0)
	begin
		// marker word
		result = packet_width'(1);
	end
	else if (entry <= last_sample_entry)
	begin
		result = {serial_number, channel, s.ion_count, marker_c, marker_b,
			s.timestamp, s.gain, s.level, marker_a, s.flag, device_id};
	end
	else
	begin
		result = '0;
	end
	return result;
endfunction

function automatic void advance_entry();
	expected_entry = (expected_entry + 1) % table_depth;
endfunction

// the first pulse after any reset carries entry 1
function automatic void restart_model();
	expected_entry = 1;
endfunction

`endif

/* verification/ion_sensor_tb.sv */
// ------------------------------
// ion sensor testbench
// table playback, pulse timing and
// random mid-run resets
// ------------------------------
`timescale 1ns/1ps

module ion_sensor_tb;
	import ion_packet_pkg::*;
	import ion_control_pkg::*;

	localparam period_t sample_period = 16'd12;
	localparam int pulse_spacing = sample_period + 3;
	localparam int timeout_cycles = 4 * pulse_spacing;
	localparam int reset_count = 6;
	localparam int packets_after_reset = 5;

	logic clock;
	logic resetn;
	logic ready;
	ion_packet_t packet;

	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int test_errors_start;
	string test_name;
	bit timed_out;
	bit prev_ready;
	bit spacing_known;
	int since_pulse;

	`include "packet_model.svh"

	ion_sensor #(
		.SAMPLE_PERIOD(sample_period)
	) dut (
		.clock(clock),
		.resetn(resetn),
		.ready(ready),
		.packet(packet)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic check_packet(string what, ion_packet_t expected);
		checks++;
		assert (packet == expected)
		else
		begin
			errors++;
			$display("Error: %s %s expected %h actual %h", test_name, what, expected, packet);
		end
	endtask

	task automatic check_count(string what, int expected, int actual);
		checks++;
		assert (actual == expected)
		else
		begin
			errors++;
			$display("Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
		end
	endtask

	// checks one cycle at the falling edge
	task automatic sample_cycle();
		@(negedge clock);
		since_pulse++;
		if (!resetn)
		begin
			restart_model();
			spacing_known = 1'b0;
			checks++;
			assert (!ready)
			else
			begin
				errors++;
				$display("%s: ready went high while reset was held", test_name);
			end
		end
		if (ready)
		begin
			checks++;
			assert (!prev_ready)
			else
			begin
				errors++;
				$display("%s: ready stayed high for two cycles in a row", test_name);
			end
			if (spacing_known)
			begin
				check_count("pulse spacing", pulse_spacing, since_pulse);
			end
			check_packet($sformatf("entry %0d", expected_entry), predict_packet(expected_entry));
			advance_entry();
			spacing_known = 1'b1;
			since_pulse = 0;
		end
		else
		begin
			check_packet("idle packet", '0);
		end
		prev_ready = ready;
	endtask

	task automatic wait_for_pulse();
		int waited;
		bit seen;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < timeout_cycles)
		begin
			sample_cycle();
			waited++;
			seen = ready;
		end
		if (!seen)
		begin
			errors++;
			timed_out = 1'b1;
			$display("%s: missing ready pulse, none within %0d cycles", test_name, timeout_cycles);
		end
	endtask

	task automatic start_test(string name);
		test_name = name;
		test_errors_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == test_errors_start)
		begin
			$display("%s passed", test_name);
		end
		else
		begin
			tests_failed++;
			$display("%s failed with %0d errors", test_name, errors - test_errors_start);
		end
	endtask

	initial
	begin
		int gap;
		int hold;
		resetn = 1'b0;
		prev_ready = 1'b0;
		spacing_known = 1'b0;
		since_pulse = 0;
		void'($urandom(32'ha333));
		load_samples();
		restart_model();
		@(posedge clock);

		start_test("reset_hold");
		repeat (10) sample_cycle();
		finish_test();
		@(posedge clock);
		resetn <= 1'b1;

		// two full passes cover the blank entries and the marker twice
		for (int pass = 1; pass <= 2 && !timed_out; pass++)
		begin
			start_test($sformatf("table_pass_%0d", pass));
			for (int n = 0; n < table_depth && !timed_out; n++)
			begin
				wait_for_pulse();
			end
			finish_test();
		end

		for (int r = 1; r <= reset_count && !timed_out; r++)
		begin
			start_test($sformatf("mid_run_reset_%0d", r));
			gap = 1 + ($urandom % 900);
			hold = 1 + ($urandom % 6);
			repeat (gap) sample_cycle();
			@(posedge clock);
			resetn <= 1'b0;
			repeat (hold) sample_cycle();
			@(posedge clock);
			resetn <= 1'b1;
			for (int n = 0; n < packets_after_reset && !timed_out; n++)
			begin
				wait_for_pulse();
			end
			finish_test();
		end

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* source/ion_sensor.sv */
// ------------------------------
// ion sensor simulator
// plays back a table of ion samples,
// one packet per sample period
// ------------------------------
`timescale 1ns/1ps

module ion_sensor
#(
	parameter ion_control_pkg::period_t SAMPLE_PERIOD = ion_control_pkg::default_sample_period
)
(
	input logic clock,
	input logic resetn,
	output logic ready,
	output ion_packet_pkg::ion_packet_t packet
);
	import ion_packet_pkg::*;
	import ion_control_pkg::*;

	logic timer_clear;
	logic timer_run;
	logic period_done;
	logic send;
	sample_index_t index;
	sample_fields_t fields;
	entry_kind_t kind;

	sample_timer #(
		.SAMPLE_PERIOD(SAMPLE_PERIOD)
	) u_timer (
		.clock(clock),
		.resetn(resetn),
		.clear(timer_clear),
		.run(timer_run),
		.period_done(period_done)
	);

	sample_sequencer u_sequencer (
		.clock(clock),
		.resetn(resetn),
		.period_done(period_done),
		.timer_clear(timer_clear),
		.timer_run(timer_run),
		.index(index),
		.send(send)
	);

	sample_table u_sample_table (
		.index(index),
		.fields(fields),
		.kind(kind)
	);

	packet_assembler u_assembler (
		.clock(clock),
		.resetn(resetn),
		.send(send),
		.fields(fields),
		.kind(kind),
		.ready(ready),
		.packet(packet)
	);

endmodule

/* source/packet_assembler.sv */
// ------------------------------
// packet assembler
// builds the 110-bit packet and sends it
// under a one-cycle ready strobe
// ------------------------------
`timescale 1ns/1ps

module packet_assembler
(
	input logic clock,
	input logic resetn,
	input logic send,
	input ion_packet_pkg::sample_fields_t fields,
	input ion_packet_pkg::entry_kind_t kind,
	output logic ready,
	output ion_packet_pkg::ion_packet_t packet
);
	import ion_packet_pkg::*;

	ion_packet_t sample_packet;
	ion_packet_t assembled;

	always_comb
	begin
		sample_packet.serial_number = serial_number;
		sample_packet.channel = channel;
		sample_packet.ion_count = fields.ion_count;
		sample_packet.marker_c = marker_c;
		sample_packet.marker_b = marker_b;
		sample_packet.timestamp = fields.timestamp;
		sample_packet.gain = fields.gain;
		sample_packet.level = fields.level;
		sample_packet.marker_a = marker_a;
		sample_packet.flag = fields.flag;
		sample_packet.device_id = device_id;
	end

	always_comb
	begin
		case (kind)
			entry_marker: assembled = marker_word;
			entry_sample: assembled = sample_packet;
			default: assembled = '0;
		endcase
	end

	// the receiver must take the packet while ready is high
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			ready <= 1'b0;
			packet <= '0;
		end
		else
		begin
			ready <= send;
			if (send)
			begin
				packet <= assembled;
			end
			else
			begin
				packet <= '0;
			end
		end
	end

endmodule

/* source/sample_table.sv */
// ------------------------------
// sample table
// read-only store of the variable fields,
// classifies each entry by its index
// ------------------------------
`timescale 1ns/1ps

module sample_table
(
	input ion_control_pkg::sample_index_t index,
	output ion_packet_pkg::sample_fields_t fields,
	output ion_packet_pkg::entry_kind_t kind
);
	import ion_packet_pkg::*;
	import ion_control_pkg::*;

	sample_fields_t samples [0:table_depth-1];

	initial
	begin
		$readmemh(sample_file, samples);
	end

	assign fields = samples[index];

	// entry 0 is the marker and the top few entries are unused
	always_comb
	begin
		if (index == '0)
		begin
			kind = entry_marker;
		end
		else if (index <= sample_index_t'(last_sample_entry))
		begin
			kind = entry_sample;
		end
		else
		begin
			kind = entry_blank;
		end
	end

endmodule

/* source/sample_sequencer.sv */
// ------------------------------
// sample sequencer
// idle, read and send FSM that owns
// the table index
// ------------------------------
`timescale 1ns/1ps

module sample_sequencer
(
	input logic clock,
	input logic resetn,
	input logic period_done,
	output logic timer_clear,
	output logic timer_run,
	output ion_control_pkg::sample_index_t index,
	output logic send
);
	import ion_control_pkg::*;

	sequencer_state_t state;
	sequencer_state_t state_next;

	always_comb
	begin
		state_next = state;
		case (state)
			state_idle:
			begin
				if (period_done)
				begin
					state_next = state_read_entry;
				end
			end
			state_read_entry:
			begin
				state_next = state_send_packet;
			end
			state_send_packet:
			begin
				state_next = state_idle;
			end
			default:
			begin
				state_next = state_idle;
			end
		endcase
	end

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			state <= state_idle;
			index <= '0;
		end
		else
		begin
			state <= state_next;
			// steps once per sample and rolls over from 63 to 0
			if (state == state_read_entry)
			begin
				index <= index + 1'b1;
			end
		end
	end

	assign timer_run = (state == state_idle);
	assign timer_clear = (state == state_read_entry);
	assign send = (state == state_send_packet);

endmodule

/* source/sample_timer.sv */
// ------------------------------
// sample timer
// counts idle cycles and flags the end
// of a sample period
// ------------------------------
`timescale 1ns/1ps

module sample_timer
#(
	parameter ion_control_pkg::period_t SAMPLE_PERIOD = ion_control_pkg::default_sample_period
)
(
	input logic clock,
	input logic resetn,
	input logic clear,
	input logic run,
	output logic period_done
);
	import ion_control_pkg::*;

	period_t count;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			count <= '0;
		end
		else if (clear)
		begin
			count <= '0;
		end
		else if (run)
		begin
			count <= count + 1'b1;
		end
	end

	// idle ends on the cycle the count reaches the period
	assign period_done = (count == SAMPLE_PERIOD);

endmodule

/* source/ion_control_pkg.sv */
// ------------------------------
// ion sensor sequencing
// table size, index and timer types,
// and the FSM states
// ------------------------------
package ion_control_pkg;

	localparam int table_depth = 64;
	localparam int last_sample_entry = 59;

	// sample table contents with the five variable fields per line
	localparam string sample_file = "source/ion_samples.hex";

	typedef logic [$clog2(table_depth)-1:0] sample_index_t;

	typedef logic [15:0] period_t;

	localparam period_t default_sample_period = 16'hffff;

	typedef enum logic [1:0] {
		state_idle,
		state_read_entry,
		state_send_packet
	} sequencer_state_t;

endpackage

/* source/ion_packet_pkg.sv */
// ------------------------------
// ion packet definitions
// field widths, fixed field values and the
// layouts of a stored sample and a sent packet
// ------------------------------
package ion_packet_pkg;

	localparam int packet_width = 110;

	// field widths
	localparam int device_id_width = 7;
	localparam int marker_width = 8;
	localparam int level_width = 8;
	localparam int gain_width = 8;
	localparam int timestamp_width = 16;
	localparam int ion_count_width = 16;
	localparam int channel_width = 6;
	localparam int serial_width = 24;

	// fields that never change between samples
	localparam logic [device_id_width-1:0] device_id = 7'd77;
	localparam logic [marker_width-1:0] marker_a = 8'd255;
	localparam logic [marker_width-1:0] marker_b = 8'd239;
	localparam logic [marker_width-1:0] marker_c = 8'd17;
	localparam logic [channel_width-1:0] channel = 6'd1;
	localparam logic [serial_width-1:0] serial_number = 24'd4272433;

	// one table entry
	// gain is usually 100 but some samples read 101
	typedef struct packed {
		logic flag;
		logic [level_width-1:0] level;
		logic [gain_width-1:0] gain;
		logic [timestamp_width-1:0] timestamp;
		logic [ion_count_width-1:0] ion_count;
	} sample_fields_t;

	// msb first
	typedef struct packed {
		logic [serial_width-1:0] serial_number;
		logic [channel_width-1:0] channel;
		logic [ion_count_width-1:0] ion_count;
		logic [marker_width-1:0] marker_c;
		logic [marker_width-1:0] marker_b;
		logic [timestamp_width-1:0] timestamp;
		logic [gain_width-1:0] gain;
		logic [level_width-1:0] level;
		logic [marker_width-1:0] marker_a;
		logic flag;
		logic [device_id_width-1:0] device_id;
	} ion_packet_t;

	typedef enum logic [1:0] {
		entry_marker,
		entry_sample,
		entry_blank
	} entry_kind_t;

	// sent for table entry 0
	localparam logic [packet_width-1:0] marker_word = packet_width'(1);

endpackage
